// ==== common/console_pkg.sv ====
/* rhythm console shared definitions */

`default_nettype none

package console_pkg;

  ////////////////////////////////////////////////////////////
  // widths and menu codes
  ////////////////////////////////////////////////////////////
  localparam int score_width = 12;
  localparam int mode_width = 2;

  // keyboard mode sits at the bottom of the menu
  localparam logic [mode_width-1:0] mode_bottom = 2'd0;
  // play mode at the top
  localparam logic [mode_width-1:0] mode_top = 2'd3;

  localparam int digit_count = 8;
  localparam int percent_scale = 100;

  ////////////////////////////////////////////////////////////
  // hex to active low gfedcba segments
  ////////////////////////////////////////////////////////////
  localparam logic [6:0] segment_table [16] = '{
    7'b100_0000, 7'b111_1001, 7'b010_0100, 7'b011_0000,
    7'b001_1001, 7'b001_0010, 7'b000_0010, 7'b111_1000,
    7'b000_0000, 7'b001_0000, 7'b000_1000, 7'b000_0011,
    7'b100_0110, 7'b010_0001, 7'b000_0110, 7'b000_1110
  };

  // three bcd places of the percentage
  typedef struct packed {
    logic [3:0] hundreds;
    logic [3:0] tens;
    logic [3:0] ones;
  } score_digits_t;

  // raw view for the power-of-sixteen adds, digit view for display
  typedef union packed {
    logic [score_width-1:0] raw;
    score_digits_t          digits;
  } score_word_t;

endpackage

`default_nettype wire

// ==== filelist.f ====
common/console_pkg.sv
logic/button_debouncer.sv
logic/mode_menu.sv
score/percent_calculator.sv
logic/seven_segment_scanner.sv
logic/rhythm_console_top.sv
verification/rhythm_console_assertions.sv
verification/rhythm_console_tb.sv

// ==== logic/button_debouncer.sv ====
/* button debouncer with press strobe */

`timescale 1ns/1ps
`default_nettype none

module button_debouncer #(
  parameter int debounce_cycles = 1_000_000
) (
  input  logic clk_in,
  input  logic reset,
  input  logic noisy,
  output logic press
);

  localparam int count_width = $clog2(debounce_cycles + 1);

  logic [2:0] sync_chain;
  logic sync_level;
  logic last_level;
  logic [count_width-1:0] stable_count;
  logic clean_level;
  logic clean_delay;

  assign sync_level = sync_chain[2];

  // three flop synchronizer
  always_ff @(posedge clk_in) begin
    sync_chain <= {sync_chain[1:0], noisy};
  end

  always_ff @(posedge clk_in) begin
    if (reset) begin
      last_level   <= sync_level;
      stable_count <= '0;
      clean_level  <= sync_level;
      clean_delay  <= sync_level;
      press        <= 1'b0;
    end else begin
      clean_delay <= clean_level;
      press       <= clean_level & ~clean_delay;
      if (sync_level != last_level) begin
        // any change restarts the stable window
        last_level   <= sync_level;
        stable_count <= '0;
      end else if (stable_count == count_width'(debounce_cycles)) begin
        clean_level <= last_level;
      end else begin
        stable_count <= stable_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/mode_menu.sv ====
/* mode menu state machine */

`timescale 1ns/1ps
`default_nettype none

module mode_menu
  import console_pkg::*;
(
  input  logic                  clk_in,
  input  logic                  reset,
  input  logic                  up_press,
  input  logic                  down_press,
  input  logic                  centre_press,
  output logic [mode_width-1:0] mode_choice,
  output logic                  mode_confirmed
);

  localparam logic state_menu = 1'b0;
  localparam logic state_confirmed = 1'b1;

  logic state;
  logic step_up;
  logic step_down;

  // opposing strobes in one cycle cancel
  assign step_up = up_press & ~down_press & (mode_choice != mode_top);
  assign step_down = down_press & ~up_press & (mode_choice != mode_bottom);

  assign mode_confirmed = (state == state_confirmed);

  ////////////////////////////////////////////////////////////
  // menu and confirmed states
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_in) begin
    if (reset) begin
      state       <= state_menu;
      mode_choice <= mode_bottom;
    end else begin
      case (state)
        state_menu: begin
          if (centre_press) begin
            // choice freezes as it stands
            state <= state_confirmed;
          end else if (step_up) begin
            mode_choice <= mode_choice + 1'b1;
          end else if (step_down) begin
            mode_choice <= mode_choice - 1'b1;
          end
        end
        state_confirmed: begin
          // up and down ignored here
          if (centre_press) begin
            state <= state_menu;
          end
        end
        default: begin
          state <= state_menu;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== logic/rhythm_console_top.sv ====
/* rhythm console front end */

`timescale 1ns/1ps
`default_nettype none

module rhythm_console_top
  import console_pkg::*;
#(
  parameter int debounce_cycles = 1_000_000,
  parameter int scan_bits = 14
) (
  input  logic                   clk_in,
  input  logic                   reset,
  input  logic                   btn_up,
  input  logic                   btn_down,
  input  logic                   btn_centre,
  input  logic                   score_start,
  input  logic [score_width-1:0] score,
  input  logic [score_width-1:0] max_score,
  output logic [mode_width-1:0]  mode_choice,
  output logic                   mode_confirmed,
  output score_word_t            percent_score,
  output logic                   percent_done,
  output logic [6:0]             segments,
  output logic [digit_count-1:0] digit_strobe
);

  logic up_press;
  logic down_press;
  logic centre_press;
  logic [digit_count*4-1:0] display_word;

  ////////////////////////////////////////////////////////////
  // buttons
  ////////////////////////////////////////////////////////////
  button_debouncer #(.debounce_cycles(debounce_cycles)) u_up_debouncer (
    .clk_in (clk_in),
    .reset  (reset),
    .noisy  (btn_up),
    .press  (up_press)
  );

  button_debouncer #(.debounce_cycles(debounce_cycles)) u_down_debouncer (
    .clk_in (clk_in),
    .reset  (reset),
    .noisy  (btn_down),
    .press  (down_press)
  );

  button_debouncer #(.debounce_cycles(debounce_cycles)) u_centre_debouncer (
    .clk_in (clk_in),
    .reset  (reset),
    .noisy  (btn_centre),
    .press  (centre_press)
  );

  mode_menu u_mode_menu (
    .clk_in         (clk_in),
    .reset          (reset),
    .up_press       (up_press),
    .down_press     (down_press),
    .centre_press   (centre_press),
    .mode_choice    (mode_choice),
    .mode_confirmed (mode_confirmed)
  );

  percent_calculator u_percent_calculator (
    .clk_in        (clk_in),
    .reset         (reset),
    .start         (score_start),
    .score         (score),
    .max_score     (max_score),
    .percent_score (percent_score),
    .done          (percent_done)
  );

  ////////////////////////////////////////////////////////////
  // display
  ////////////////////////////////////////////////////////////

  // mode on the left, percentage on the right
  assign display_word = {
    {(4 - mode_width){1'b0}}, mode_choice,
    {((digit_count - 4) * 4){1'b0}},
    percent_score.digits.hundreds,
    percent_score.digits.tens,
    percent_score.digits.ones
  };

  seven_segment_scanner #(.scan_bits(scan_bits)) u_seven_segment_scanner (
    .clk_in       (clk_in),
    .reset        (reset),
    .display_word (display_word),
    .segments     (segments),
    .digit_strobe (digit_strobe)
  );

endmodule

`default_nettype wire

// ==== logic/seven_segment_scanner.sv ====
/* eight digit hex display scanner */

`timescale 1ns/1ps
`default_nettype none

module seven_segment_scanner
  import console_pkg::*;
#(
  parameter int scan_bits = 14
) (
  input  logic                     clk_in,
  input  logic                     reset,
  input  logic [digit_count*4-1:0] display_word,
  output logic [6:0]               segments,
  output logic [digit_count-1:0]   digit_strobe
);

  localparam int select_bits = $clog2(digit_count);

  logic [scan_bits-1:0] scan_count;
  logic [select_bits-1:0] scan_slot;
  logic [select_bits-1:0] digit_index;
  logic [3:0] digit_value;
  logic [digit_count-1:0] digit_onehot;

  ////////////////////////////////////////////////////////////
  // digit selection
  ////////////////////////////////////////////////////////////

  // top bits of the refresh counter pick the slot
  assign scan_slot = scan_count[scan_bits-1 -: select_bits];

  // slot 0 is the leftmost digit
  assign digit_index = select_bits'(digit_count - 1) - scan_slot;

  assign digit_value = display_word[{digit_index, 2'b00} +: 4];

  assign digit_onehot = digit_count'(1) << digit_index;

  ////////////////////////////////////////////////////////////
  // registered outputs
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_in) begin
    if (reset) begin
      scan_count   <= '0;
      // blank until scanning starts
      segments     <= '1;
      digit_strobe <= '1;
    end else begin
      scan_count   <= scan_count + 1'b1;
      segments     <= segment_table[digit_value];
      digit_strobe <= ~digit_onehot;
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rhythm console testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module rhythm_console_tb -f filelist.f -o rhythm_console_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/rhythm_console_sim +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

// ==== score/percent_calculator.sv ====
/* iterative score percentage */

`timescale 1ns/1ps
`default_nettype none

module percent_calculator
  import console_pkg::*;
(
  input  logic                   clk_in,
  input  logic                   reset,
  input  logic                   start,
  input  logic [score_width-1:0] score,
  input  logic [score_width-1:0] max_score,
  output score_word_t            percent_score,
  output logic                   done
);

  localparam int dividend_width = $clog2(percent_scale * ((1 << score_width) - 1) + 1);
  localparam logic [1:0] place_hundreds = 2'd2;
  localparam logic [1:0] place_ones = 2'd0;

  logic [dividend_width-1:0] dividend;
  logic [score_width-1:0] divisor;
  logic [1:0] place;
  logic busy;

  logic [6:0] power_of_ten;
  logic [score_width-1:0] power_of_sixteen;
  logic [dividend_width-1:0] place_amount;
  logic fits;

  ////////////////////////////////////////////////////////////
  // place value tables
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (place)
      2'd2: begin
        power_of_ten = 7'd100;
        power_of_sixteen = 12'h100;
      end
      2'd1: begin
        power_of_ten = 7'd10;
        power_of_sixteen = 12'h010;
      end
      default: begin
        power_of_ten = 7'd1;
        power_of_sixteen = 12'h001;
      end
    endcase
  end

  assign place_amount = dividend_width'(power_of_ten) * dividend_width'(divisor);
  // zero divisor never fits so the places just run out
  assign fits = (divisor != '0) && (dividend >= place_amount);

  // dividend and divisor
  always_ff @(posedge clk_in) begin
    if (start) begin
      dividend <= dividend_width'(percent_scale) * dividend_width'(score);
      divisor  <= max_score;
    end else if (busy && fits) begin
      dividend <= dividend - place_amount;
    end
  end

  ////////////////////////////////////////////////////////////
  // place sequencing and result
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_in) begin
    if (reset) begin
      busy          <= 1'b0;
      done          <= 1'b0;
      place         <= place_hundreds;
      percent_score <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy          <= 1'b1;
        place         <= place_hundreds;
        percent_score <= '0;
      end else if (busy) begin
        if (fits) begin
          percent_score.raw <= percent_score.raw + power_of_sixteen;
        end else if (place == place_ones) begin
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          place <= place - 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/rhythm_console_assertions.sv ====
/* rhythm console bound checks */

`timescale 1ns/1ps
`default_nettype none

module rhythm_console_assertions
  import console_pkg::*;
#(
  parameter int debounce_cycles = 16
) (
  input logic                     clk_in,
  input logic                     reset,
  input logic                     btn_up,
  input logic                     btn_down,
  input logic                     btn_centre,
  input logic                     up_press,
  input logic                     down_press,
  input logic                     centre_press,
  input logic                     score_start,
  input logic [score_width-1:0]   score,
  input logic [score_width-1:0]   max_score,
  input logic [mode_width-1:0]    mode_choice,
  input logic                     mode_confirmed,
  input score_word_t              percent_score,
  input logic                     percent_done,
  input logic [6:0]               segments,
  input logic [digit_count-1:0]   digit_strobe
);

  int up_high;
  int down_high;
  int centre_high;
  int expect_value;
  int wait_cycles;
  int strobe_index;
  int failure_count;
  logic pending;
  logic scan_live;
  logic expect_confirmed;
  logic [mode_width-1:0] expect_choice;
  logic [score_width-1:0] expect_word;
  logic [digit_count*4-1:0] prev_word;
  logic [6:0] expect_segments;
  logic ok_debounce;
  logic ok_choice;
  logic ok_confirm;
  logic ok_value;
  logic ok_latency;
  logic ok_onehot;
  logic ok_segments;

  ////////////////////////////////////////////////////////////
  // reference models
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_in) begin
    if (reset) begin
      up_high          <= 0;
      down_high        <= 0;
      centre_high      <= 0;
      expect_choice    <= mode_bottom;
      expect_confirmed <= 1'b0;
      pending          <= 1'b0;
      wait_cycles      <= 0;
      scan_live        <= 1'b0;
    end else begin
      // length of the current high run of each button
      up_high     <= btn_up ? up_high + 1 : 0;
      down_high   <= btn_down ? down_high + 1 : 0;
      centre_high <= btn_centre ? centre_high + 1 : 0;
      // menu model keeps its own choice and confirm state
      expect_confirmed <= expect_confirmed ^ centre_press;
      if (!expect_confirmed && !centre_press && up_press && !down_press &&
          expect_choice != mode_top) begin
        expect_choice <= expect_choice + 1'b1;
      end else if (!expect_confirmed && !centre_press && down_press && !up_press &&
                   expect_choice != mode_bottom) begin
        expect_choice <= expect_choice - 1'b1;
      end
      if (score_start) begin
        pending      <= 1'b1;
        wait_cycles  <= 0;
        expect_value <= (max_score == '0) ? 0 :
                        (percent_scale * int'(score)) / int'(max_score);
      end else if (pending) begin
        pending     <= !percent_done;
        wait_cycles <= wait_cycles + 1;
      end
      scan_live <= 1'b1;
    end
    // display word as the scanner saw it one cycle ago
    prev_word <= {2'b00, mode_choice, 16'h0000, percent_score.digits.hundreds,
                  percent_score.digits.tens, percent_score.digits.ones};
  end

  always_comb begin
    strobe_index = 0;
    for (int k = 0; k < digit_count; k++) begin
      if (!digit_strobe[k]) begin
        strobe_index = k;
      end
    end
  end

  assign expect_word = {4'(expect_value / 100), 4'((expect_value / 10) % 10),
                        4'(expect_value % 10)};
  assign expect_segments = segment_table[prev_word[strobe_index*4 +: 4]];

  assign ok_debounce = !((up_press && up_high < debounce_cycles) ||
                         (down_press && down_high < debounce_cycles) ||
                         (centre_press && centre_high < debounce_cycles));
  assign ok_choice = (mode_choice == expect_choice);
  assign ok_confirm = (mode_confirmed == expect_confirmed);
  assign ok_value = !percent_done || (percent_score.raw == expect_word);
  assign ok_latency = !pending || (wait_cycles <= 24);
  assign ok_onehot = !scan_live || $onehot(~digit_strobe);
  assign ok_segments = !scan_live || (segments == expect_segments);

  always_ff @(posedge clk_in) begin
    if (reset) begin
      failure_count <= 0;
    end else begin
      failure_count <= failure_count + $countones({!ok_debounce, !ok_choice, !ok_confirm,
                                                   !ok_value, !ok_latency, !ok_onehot,
                                                   !ok_segments});
    end
  end

  ////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////
  a_debounce: assert property (@(posedge clk_in) disable iff (reset) ok_debounce)
    else $error("debounce: press strobe from a button that was not held stable");
  a_choice: assert property (@(posedge clk_in) disable iff (reset) ok_choice)
    else $error("Error menu_choice: expected %0d actual %0d", expect_choice, mode_choice);
  a_confirm: assert property (@(posedge clk_in) disable iff (reset) ok_confirm)
    else $error("Error menu_confirm: expected %0d actual %0d", expect_confirmed,
                mode_confirmed);
  a_value: assert property (@(posedge clk_in) disable iff (reset) ok_value)
    else $error("Error percent_value: expected %h actual %h", expect_word,
                percent_score.raw);
  a_latency: assert property (@(posedge clk_in) disable iff (reset) ok_latency)
    else $error("percent: no done strobe within 24 cycles of the start strobe");
  a_onehot: assert property (@(posedge clk_in) disable iff (reset) ok_onehot)
    else $error("scan: digit strobe does not have exactly one digit on");
  a_segments: assert property (@(posedge clk_in) disable iff (reset) ok_segments)
    else $error("Error scan_segments: expected %b actual %b", expect_segments, segments);

endmodule

bind rhythm_console_top rhythm_console_assertions #(
  .debounce_cycles(debounce_cycles)
) u_checks (.*);

`default_nettype wire

// ==== verification/rhythm_console_tb.sv ====
/* rhythm console testbench */

`timescale 1ns/1ps
`default_nettype none

module rhythm_console_tb
  import console_pkg::*;
();

  localparam int clock_half = 4;
  localparam int press_high = 30;
  localparam int press_low = 30;
  localparam int score_wait = 30;
  localparam int score_pairs = 60;
  localparam int press_budget = 40;
  // all presses, all scores, reset and some margin
  localparam int watchdog_cycles = press_budget * (press_high + press_low) +
                                   (score_pairs + 10) * (score_wait + 4) + 10 + 500;

  logic clk_in = 1'b0;
  logic reset;
  logic btn_up;
  logic btn_down;
  logic btn_centre;
  logic score_start;
  logic [score_width-1:0] score;
  logic [score_width-1:0] max_score;
  logic [mode_width-1:0] mode_choice;
  logic mode_confirmed;
  score_word_t percent_score;
  logic percent_done;
  logic [6:0] segments;
  logic [digit_count-1:0] digit_strobe;
  int tb_failures = 0;
  int assert_failures;

  rhythm_console_top #(
    .debounce_cycles(16),
    .scan_bits(4)
  ) u_rhythm_console_top (.*);

  always #(clock_half) clk_in = ~clk_in;

  ////////////////////////////////////////////////////////////
  // button index 0 is up, 1 is down and 2 is centre
  ////////////////////////////////////////////////////////////
  task automatic set_button(input int which, input logic level);
    case (which)
      0: btn_up <= level;
      1: btn_down <= level;
      default: btn_centre <= level;
    endcase
  endtask

  function automatic logic press_strobe(input int which);
    case (which)
      0: return u_rhythm_console_top.up_press;
      1: return u_rhythm_console_top.down_press;
      default: return u_rhythm_console_top.centre_press;
    endcase
  endfunction

  task automatic press_button(input int which);
    logic seen;
    seen = 1'b0;
    set_button(which, 1'b1);
    for (int i = 0; i < press_high; i++) begin
      @(negedge clk_in);
      if (press_strobe(which)) begin
        seen = 1'b1;
      end
      @(posedge clk_in);
    end
    set_button(which, 1'b0);
    repeat (press_low) @(posedge clk_in);
    if (!seen) begin
      $display("button %0d was held but gave no press strobe", which);
      tb_failures++;
    end
  endtask

  // high runs all shorter than the debounce window
  task automatic bounce_button(input int which);
    int widths [4];
    widths = '{3, 7, 12, 5};
    foreach (widths[i]) begin
      set_button(which, 1'b1);
      repeat (widths[i]) @(posedge clk_in);
      set_button(which, 1'b0);
      repeat (4) @(posedge clk_in);
    end
    repeat (press_low) @(posedge clk_in);
  endtask

  task automatic run_score(input logic [score_width-1:0] s,
                           input logic [score_width-1:0] m);
    int waited;
    score       <= s;
    max_score   <= m;
    score_start <= 1'b1;
    @(posedge clk_in);
    score_start <= 1'b0;
    waited = 0;
    do begin
      @(negedge clk_in);
      waited++;
    end while (!percent_done && waited < score_wait);
    if (!percent_done) begin
      $display("score %0d of %0d gave no percent_done strobe", s, m);
      tb_failures++;
    end
    @(posedge clk_in);
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int seed;
    logic [score_width-1:0] m;
    seed = $urandom(34);
    reset = 1'b1;
    btn_up = 1'b0;
    btn_down = 1'b0;
    btn_centre = 1'b0;
    score_start = 1'b0;
    score = '0;
    max_score = '0;
    repeat (10) @(posedge clk_in);
    reset <= 1'b0;
    bounce_button(0);
    press_button(0);
    // down past the bottom, then up past the top
    for (int i = 0; i < 3; i++) begin
      press_button(1);
    end
    for (int i = 0; i < 4; i++) begin
      press_button(0);
    end
    press_button(2);
    press_button(1);
    press_button(0);
    press_button(2);
    press_button(1);
    run_score(0, 100);
    run_score(500, 500);
    run_score(0, 0);
    run_score(4095, 4095);
    run_score(1, 4095);
    run_score(4094, 4095);
    for (int i = 0; i < score_pairs; i++) begin
      m = score_width'($urandom % 4096);
      run_score(score_width'($urandom % (32'(m) + 1)), m);
    end
    repeat (20) @(posedge clk_in);
    assert_failures = u_rhythm_console_top.u_checks.failure_count;
    $display("assertion failures: %0d, testbench failures: %0d", assert_failures,
             tb_failures);
    if (assert_failures == 0 && tb_failures == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(watchdog_cycles * 2 * clock_half);
    $display("timeout after %0d cycles, the test sequence never finished",
             watchdog_cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
